// File: bench/lsu_checker.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                req,
    input  logic                wen,
    input  logic                ren,
    input  logic                sign,
    input  lsu_pkg::acc_size_t  size,
    input  lsu_pkg::addr_t      addr,
    input  lsu_pkg::word_t      wdata,
    input  lsu_pkg::word_t      rdata,
    input  logic                done,
    input  logic                err,
    input  string               name,
    input  logic                use_exp,
    input  lsu_pkg::word_t      exp_rdata,
    input  logic                exp_err,
    output int                  n_checked,
    output int                  n_failed
);

    localparam int MEM_BYTES = `LSU_NUM_BANKS * `LSU_BANK_WORDS * 4;
    localparam int MAX_WAIT  = 8;

    logic [7:0]         ref_mem [MEM_BYTES]; // byte image of all banks
    logic               busy;
    int                 cyc;
    string              c_name;
    logic               c_wen, c_ren, c_sign, c_use_exp, c_exp_err;
    lsu_pkg::acc_size_t c_size;
    lsu_pkg::addr_t     c_addr;
    lsu_pkg::word_t     c_wdata, c_exp_rdata;

    function automatic int size_bytes(input lsu_pkg::acc_size_t s);
        case (s)
            lsu_pkg::SIZE_BYTE: return 1;
            lsu_pkg::SIZE_HALF: return 2;
            lsu_pkg::SIZE_WORD: return 4;
            default:            return 0;
        endcase
    endfunction

    function automatic logic in_range(input lsu_pkg::addr_t a);
        return (a >= `LSU_MEM_BASE) && ((a - `LSU_MEM_BASE) < MEM_BYTES);
    endfunction

    function automatic lsu_pkg::word_t model_load(input lsu_pkg::addr_t a,
                                                  input lsu_pkg::acc_size_t s,
                                                  input logic sg);
        lsu_pkg::word_t v;
        int             n;
        int             off;
        v = '0;
        n = size_bytes(s);
        if (!in_range(a))
            return '0; // decode error reads as zero
        off = int'(a - `LSU_MEM_BASE);
        for (int i = 0; i < n; i++)
            v[8*i +: 8] = ref_mem[off + i];
        if (sg && n == 1 && v[7])
            v[31:8] = '1;
        if (sg && n == 2 && v[15])
            v[31:16] = '1;
        return v;
    endfunction

    task automatic store_model(input lsu_pkg::addr_t a, input lsu_pkg::acc_size_t s,
                               input lsu_pkg::word_t d);
        int off;
        off = int'(a - `LSU_MEM_BASE);
        for (int i = 0; i < size_bytes(s); i++)
            ref_mem[off + i] = d[8*i +: 8]; // low bytes land on the addressed lanes
    endtask

    task automatic score_test();
        lsu_pkg::word_t exp_rd;
        int             exp_cyc;
        logic           bad;
        exp_cyc = c_ren ? 3 : (c_wen ? 4 : 0);
        exp_rd  = c_use_exp ? c_exp_rdata : model_load(c_addr, c_size, c_sign);
        bad     = 1'b1;
        if (c_ren && rdata !== exp_rd)
            $display("error %s @%h rdata expected %h actual %h", c_name, c_addr, exp_rd, rdata);
        else if (err !== c_exp_err)
            $display("error %s @%h err expected %b actual %b", c_name, c_addr, c_exp_err, err);
        else if (cyc != exp_cyc)
            $display("%s @%h: done came %0d cycles after the request instead of %0d",
                     c_name, c_addr, cyc, exp_cyc);
        else begin
            $display("pass  %s @%h", c_name, c_addr);
            bad = 1'b0;
        end
        if (c_wen && !c_ren && in_range(c_addr))
            store_model(c_addr, c_size, c_wdata);
        n_checked = n_checked + 1;
        if (bad)
            n_failed = n_failed + 1;
        busy = 1'b0;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            busy      = 1'b0;
            cyc       = 0;
            n_checked = 0;
            n_failed  = 0;
        end else begin
            if (busy)
                cyc = cyc + 1;
            else if (req) begin
                c_name      = name;
                c_wen       = wen;
                c_ren       = ren;
                c_sign      = sign;
                c_size      = size;
                c_addr      = addr;
                c_wdata     = wdata;
                c_use_exp   = use_exp;
                c_exp_rdata = exp_rdata;
                c_exp_err   = exp_err;
                cyc         = 0;
                busy        = 1'b1;
            end
            if (busy && done)
                score_test();
            else if (busy && cyc > MAX_WAIT) begin
                $display("%s @%h: no done within %0d cycles of the request",
                         c_name, c_addr, MAX_WAIT);
                n_checked = n_checked + 1;
                n_failed  = n_failed + 1;
                busy      = 1'b0;
            end
        end
    end

endmodule

// File: bench/lsu_sys_tb.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_sys_tb;

    typedef struct packed {
        logic               wen;
        logic               ren;
        lsu_pkg::acc_size_t size;
        logic               sign;
        lsu_pkg::addr_t     addr;
        lsu_pkg::word_t     wdata;
        logic               use_exp;  // exp_rdata column holds a fixed value
        lsu_pkg::word_t     exp_rdata;
        logic               exp_err;
    } test_row_t;

    localparam lsu_pkg::acc_size_t SZ_N = lsu_pkg::SIZE_NONE;
    localparam lsu_pkg::acc_size_t SZ_B = lsu_pkg::SIZE_BYTE;
    localparam lsu_pkg::acc_size_t SZ_H = lsu_pkg::SIZE_HALF;
    localparam lsu_pkg::acc_size_t SZ_W = lsu_pkg::SIZE_WORD;
    localparam lsu_pkg::addr_t     MEM  = `LSU_MEM_BASE;
    localparam lsu_pkg::addr_t     BANK_BYTES = `LSU_BANK_WORDS * 4;

    logic               clk;
    logic               reset;
    logic               req, wen, ren, sign;
    lsu_pkg::acc_size_t size;
    lsu_pkg::addr_t     addr;
    lsu_pkg::word_t     wdata;
    lsu_pkg::word_t     rdata;
    logic               done, err;

    string              cur_name;
    logic               cur_use_exp;
    lsu_pkg::word_t     cur_exp_rdata;
    logic               cur_exp_err;
    int                 n_checked, n_failed;

    test_row_t          rows[$];
    string              names[$];
    int                 cycles;
    int                 cycle_limit = 1000000;

    lsu_sys u_dut (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .wen   (wen),
        .ren   (ren),
        .sign  (sign),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .err   (err)
    );

    lsu_checker u_chk (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .wen       (wen),
        .ren       (ren),
        .sign      (sign),
        .size      (size),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .done      (done),
        .err       (err),
        .name      (cur_name),
        .use_exp   (cur_use_exp),
        .exp_rdata (cur_exp_rdata),
        .exp_err   (cur_exp_err),
        .n_checked (n_checked),
        .n_failed  (n_failed)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_store(input string n, input lsu_pkg::acc_size_t s,
                             input lsu_pkg::addr_t a, input lsu_pkg::word_t d,
                             input logic rnd, input logic e);
        test_row_t r;
        r         = '0;
        r.wen     = 1'b1;
        r.size    = s;
        r.addr    = a;
        r.wdata   = rnd ? $urandom : d;
        r.exp_err = e;
        rows.push_back(r);
        names.push_back(n);
    endtask

    task automatic add_load(input string n, input lsu_pkg::acc_size_t s, input logic sg,
                            input lsu_pkg::addr_t a, input logic fixed,
                            input lsu_pkg::word_t exp, input logic e);
        test_row_t r;
        r           = '0;
        r.ren       = 1'b1;
        r.size      = s;
        r.sign      = sg;
        r.addr      = a;
        r.use_exp   = fixed;
        r.exp_rdata = exp;
        r.exp_err   = e;
        rows.push_back(r);
        names.push_back(n);
    endtask

    task automatic add_nop(input string n, input lsu_pkg::acc_size_t s);
        test_row_t r;
        r      = '0;
        r.size = s;
        r.addr = MEM;
        rows.push_back(r);
        names.push_back(n);
    endtask

    task automatic build_table();
        lsu_pkg::addr_t first;
        lsu_pkg::addr_t last;
        add_store("st_word", SZ_W, MEM + 32'h10, 32'h0, 1'b1, 1'b0);
        add_load("ld_word", SZ_W, 1'b0, MEM + 32'h10, 1'b0, 32'h0, 1'b0);
        // lane merging with junk in the upper data bits
        add_store("st_base", SZ_W, MEM + 32'h20, 32'h1122_3344, 1'b0, 1'b0);
        add_store("st_b1", SZ_B, MEM + 32'h21, 32'h1234_56aa, 1'b0, 1'b0);
        add_store("st_b3", SZ_B, MEM + 32'h23, 32'hffff_ffbb, 1'b0, 1'b0);
        add_store("st_b0", SZ_B, MEM + 32'h20, 32'h0000_00ee, 1'b0, 1'b0);
        add_store("st_b2", SZ_B, MEM + 32'h22, 32'h7777_7799, 1'b0, 1'b0);
        add_load("ld_merged_b", SZ_W, 1'b0, MEM + 32'h20, 1'b1, 32'hbb99_aaee, 1'b0);
        add_store("st_base2", SZ_W, MEM + 32'h24, 32'h5566_7788, 1'b0, 1'b0);
        add_store("st_h0", SZ_H, MEM + 32'h24, 32'hf0f0_ccdd, 1'b0, 1'b0);
        add_store("st_h2", SZ_H, MEM + 32'h26, 32'h0000_1357, 1'b0, 1'b0);
        add_load("ld_merged_h", SZ_W, 1'b0, MEM + 32'h24, 1'b1, 32'h1357_ccdd, 1'b0);
        // sub-word loads at each offset
        add_load("lb_0", SZ_B, 1'b1, MEM + 32'h20, 1'b1, 32'hffff_ffee, 1'b0);
        add_load("lbu_0", SZ_B, 1'b0, MEM + 32'h20, 1'b1, 32'h0000_00ee, 1'b0);
        add_load("lb_1", SZ_B, 1'b1, MEM + 32'h21, 1'b1, 32'hffff_ffaa, 1'b0);
        add_load("lbu_1", SZ_B, 1'b0, MEM + 32'h21, 1'b1, 32'h0000_00aa, 1'b0);
        add_load("lb_2", SZ_B, 1'b1, MEM + 32'h22, 1'b1, 32'hffff_ff99, 1'b0);
        add_load("lbu_2", SZ_B, 1'b0, MEM + 32'h22, 1'b1, 32'h0000_0099, 1'b0);
        add_load("lbu_3", SZ_B, 1'b0, MEM + 32'h23, 1'b1, 32'h0000_00bb, 1'b0);
        add_load("lb_3", SZ_B, 1'b1, MEM + 32'h23, 1'b1, 32'hffff_ffbb, 1'b0);
        add_load("lb_pos", SZ_B, 1'b1, MEM + 32'h26, 1'b1, 32'h0000_0057, 1'b0);
        add_load("lh_0", SZ_H, 1'b1, MEM + 32'h20, 1'b1, 32'hffff_aaee, 1'b0);
        add_load("lhu_0", SZ_H, 1'b0, MEM + 32'h20, 1'b1, 32'h0000_aaee, 1'b0);
        add_load("lh_2", SZ_H, 1'b1, MEM + 32'h22, 1'b1, 32'hffff_bb99, 1'b0);
        add_load("lhu_2", SZ_H, 1'b0, MEM + 32'h22, 1'b1, 32'h0000_bb99, 1'b0);
        add_load("lh_pos", SZ_H, 1'b1, MEM + 32'h26, 1'b1, 32'h0000_1357, 1'b0);
        for (int b = 0; b < `LSU_NUM_BANKS; b++) begin
            first = MEM + 32'(b) * BANK_BYTES;
            last  = first + BANK_BYTES - 32'h4;
            add_store("bank_first_st", SZ_W, first, 32'h0, 1'b1, 1'b0);
            add_store("bank_last_st", SZ_W, last, 32'h0, 1'b1, 1'b0);
        end
        for (int b = 0; b < `LSU_NUM_BANKS; b++) begin
            first = MEM + 32'(b) * BANK_BYTES;
            last  = first + BANK_BYTES - 32'h4;
            add_load("bank_first_ld", SZ_W, 1'b0, first, 1'b0, 32'h0, 1'b0);
            add_load("bank_last_ld", SZ_W, 1'b0, last, 1'b0, 32'h0, 1'b0);
        end
        // these would alias onto bank 3 and bank 0 if the decode wrapped
        add_store("st_below", SZ_W, MEM - 32'h4, 32'hdead_beef, 1'b0, 1'b1);
        add_load("ld_below", SZ_W, 1'b0, MEM - 32'h4, 1'b1, 32'h0, 1'b1);
        add_store("st_past", SZ_W, MEM + 32'h400, 32'hcafe_f00d, 1'b0, 1'b1);
        add_load("ld_past", SZ_W, 1'b0, MEM + 32'h400, 1'b1, 32'h0, 1'b1);
        add_load("lb_past", SZ_B, 1'b1, MEM + 32'h401, 1'b1, 32'h0, 1'b1);
        add_load("ld_bank0_chk", SZ_W, 1'b0, MEM, 1'b0, 32'h0, 1'b0);
        add_load("ld_bank3_chk", SZ_W, 1'b0, MEM + 32'h3fc, 1'b0, 32'h0, 1'b0);
        add_nop("nop", SZ_N);
        add_nop("nop_word", SZ_W);
    endtask

    task automatic run_row(input int i);
        int start;
        int waited;
        start  = n_checked;
        waited = 0;
        @(negedge clk);
        cur_name      = names[i];
        cur_use_exp   = rows[i].use_exp;
        cur_exp_rdata = rows[i].exp_rdata;
        cur_exp_err   = rows[i].exp_err;
        wen           = rows[i].wen;
        ren           = rows[i].ren;
        size          = rows[i].size;
        sign          = rows[i].sign;
        addr          = rows[i].addr;
        wdata         = rows[i].wdata;
        req           = 1'b1;
        @(negedge clk);
        req = 1'b0; // one-cycle strobe
        while (n_checked == start && waited < 12) begin
            @(negedge clk);
            waited++;
        end
    endtask

    initial begin
        void'($urandom(32'hf5e3_456e));
        reset         = 1'b1;
        req           = 1'b0;
        wen           = 1'b0;
        ren           = 1'b0;
        sign          = 1'b0;
        size          = SZ_N;
        addr          = '0;
        wdata         = '0;
        cur_name      = "";
        cur_use_exp   = 1'b0;
        cur_exp_rdata = '0;
        cur_exp_err   = 1'b0;
        build_table();
        cycle_limit = rows.size() * 10 + 20;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (rows[i])
            run_row(i);
        $display("checked %0d of %0d tests, %0d failed", n_checked, rows.size(), n_failed);
        if (n_failed == 0 && n_checked == rows.size())
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles before the table was finished", cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: hdl/bus_decode.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module bus_decode (
    input  lsu_pkg::addr_t              addr,
    input  logic                        arvalid,
    input  logic                        awvalid,
    input  logic                        wvalid,
    output logic                        arready,
    output logic                        awready,
    output logic                        wready,
    output logic [`LSU_NUM_BANKS-1:0]   sel_arvalid,
    output logic [`LSU_NUM_BANKS-1:0]   sel_awvalid,
    output logic [`LSU_NUM_BANKS-1:0]   sel_wvalid,
    input  logic [`LSU_NUM_BANKS-1:0]   bank_arready,
    input  logic [`LSU_NUM_BANKS-1:0]   bank_awready,
    input  logic [`LSU_NUM_BANKS-1:0]   bank_wready,
    output logic [`LSU_BANK_IDX_W-1:0]  tgt,
    output logic                        unmapped
);

    localparam int unsigned MEM_BYTES = `LSU_NUM_BANKS * `LSU_BANK_WORDS * 4;

    lsu_pkg::addr_t offset;

    assign offset = addr - `LSU_MEM_BASE;

    // below the base wraps to a large offset
    assign unmapped = (offset >= MEM_BYTES);
    assign tgt      = offset[2 + `LSU_WORD_IDX_W +: `LSU_BANK_IDX_W];

    for (genvar i = 0; i < `LSU_NUM_BANKS; i++) begin : g_sel
        assign sel_arvalid[i] = arvalid && !unmapped && (int'(tgt) == i);
        assign sel_awvalid[i] = awvalid && !unmapped && (int'(tgt) == i);
        assign sel_wvalid[i]  = wvalid  && !unmapped && (int'(tgt) == i);
    end

    // unmapped accesses are accepted here and answered by resp_select
    assign arready = unmapped ? 1'b1 : bank_arready[tgt];
    assign awready = unmapped ? 1'b1 : bank_awready[tgt];
    assign wready  = unmapped ? 1'b1 : bank_wready[tgt];

endmodule

// File: hdl/lsu.sv
`timescale 1ns/1ps

module lsu (
    input  logic                clk,
    input  logic                reset,
    input  logic                req,
    input  logic                wen,
    input  logic                ren,
    input  logic                sign,
    input  lsu_pkg::acc_size_t  size,
    input  lsu_pkg::addr_t      addr,
    input  lsu_pkg::word_t      wdata,
    output lsu_pkg::word_t      rdata,
    output logic                done,
    output logic                err,
    output lsu_pkg::bus_req_t   bus_req,
    output logic                arvalid,
    output logic                awvalid,
    output logic                wvalid,
    output logic                rready,
    output logic                bready,
    input  logic                arready,
    input  logic                awready,
    input  logic                wready,
    input  logic                rvalid,
    input  logic                bvalid,
    input  lsu_pkg::bus_rsp_t   bus_rsp
);

    lsu_pkg::lsu_state_t state, state_nxt;

    lsu_pkg::addr_t     acc_addr;
    lsu_pkg::word_t     acc_wdata;
    lsu_pkg::acc_size_t acc_size;
    logic               acc_sign;
    lsu_pkg::word_t     rdata_q;
    logic               err_q;
    logic [4:0]         lane_shift;
    lsu_pkg::strb_t     wstrb;
    lsu_pkg::word_t     rd_shifted;

    assign rready = 1'b1;
    assign bready = 1'b1;

    always_comb begin
        state_nxt = state;
        unique case (state)
            lsu_pkg::ST_IDLE: begin
                if (req && ren)
                    state_nxt = lsu_pkg::ST_RADDR;
                else if (req && wen)
                    state_nxt = lsu_pkg::ST_WADDR;
            end
            lsu_pkg::ST_RADDR: if (arready) state_nxt = lsu_pkg::ST_RDATA;
            lsu_pkg::ST_RDATA: if (rvalid && rready) state_nxt = lsu_pkg::ST_DONE;
            lsu_pkg::ST_WADDR: if (awready) state_nxt = lsu_pkg::ST_WDATA;
            lsu_pkg::ST_WDATA: if (wready) state_nxt = lsu_pkg::ST_WRESP;
            lsu_pkg::ST_WRESP: if (bvalid && bready) state_nxt = lsu_pkg::ST_DONE;
            default: state_nxt = lsu_pkg::ST_IDLE; // ST_DONE lasts one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= lsu_pkg::ST_IDLE;
            err_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == lsu_pkg::ST_IDLE && req)
                err_q <= 1'b0;
            else if ((state == lsu_pkg::ST_RDATA && rvalid && rready) ||
                     (state == lsu_pkg::ST_WRESP && bvalid && bready))
                err_q <= (bus_rsp.resp != lsu_pkg::RESP_OKAY);
        end
    end

    // request payload held for the whole access
    always_ff @(posedge clk) begin
        if (state == lsu_pkg::ST_IDLE && req) begin
            acc_addr  <= addr;
            acc_wdata <= wdata;
            acc_size  <= size;
            acc_sign  <= sign;
        end
        if (state == lsu_pkg::ST_RDATA && rvalid && rready)
            rdata_q <= bus_rsp.rdata;
    end

    assign arvalid = (state == lsu_pkg::ST_RADDR);
    assign awvalid = (state == lsu_pkg::ST_WADDR);
    assign wvalid  = (state == lsu_pkg::ST_WDATA);

    assign lane_shift = {acc_addr[1:0], 3'b000};

    always_comb begin
        unique case (acc_size)
            lsu_pkg::SIZE_BYTE: wstrb = 4'b0001 << acc_addr[1:0];
            lsu_pkg::SIZE_HALF: wstrb = acc_addr[1] ? 4'b1100 : 4'b0011;
            lsu_pkg::SIZE_WORD: wstrb = 4'b1111;
            default:            wstrb = 4'b0000;
        endcase
    end

    assign bus_req.addr  = acc_addr;
    assign bus_req.wdata = acc_wdata << lane_shift;
    assign bus_req.wstrb = wstrb;

    // loads are aligned and then extended
    assign rd_shifted = rdata_q >> lane_shift;

    always_comb begin
        unique case (acc_size)
            lsu_pkg::SIZE_BYTE: rdata = {{24{rd_shifted[7] & acc_sign}}, rd_shifted[7:0]};
            lsu_pkg::SIZE_HALF: rdata = {{16{rd_shifted[15] & acc_sign}}, rd_shifted[15:0]};
            lsu_pkg::SIZE_WORD: rdata = rd_shifted;
            default:            rdata = '0;
        endcase
    end

    // no enable means an immediate completion
    assign done = (state == lsu_pkg::ST_DONE) ||
                  (state == lsu_pkg::ST_IDLE && req && !wen && !ren);
    assign err  = (state == lsu_pkg::ST_DONE) && err_q;

endmodule

// File: hdl/lsu_pkg.sv
package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // same encoding as the old mask input
    typedef enum logic [1:0] {
        SIZE_NONE = 2'b00,
        SIZE_BYTE = 2'b01,
        SIZE_HALF = 2'b10,
        SIZE_WORD = 2'b11
    } acc_size_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RADDR,
        ST_RDATA,
        ST_WADDR,
        ST_WDATA,
        ST_WRESP,
        ST_DONE
    } lsu_state_t;

    // one address per access, so ar, aw and w share this
    typedef struct packed {
        addr_t addr;
        word_t wdata; // already on its byte lanes
        strb_t wstrb;
    } bus_req_t;

    typedef struct packed {
        word_t rdata;
        resp_t resp;
    } bus_rsp_t;

endpackage

// File: hdl/lsu_sys.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_sys (
    input  logic                clk,
    input  logic                reset,
    input  logic                req,
    input  logic                wen,
    input  logic                ren,
    input  logic                sign,
    input  lsu_pkg::acc_size_t  size,
    input  lsu_pkg::addr_t      addr,
    input  lsu_pkg::word_t      wdata,
    output lsu_pkg::word_t      rdata,
    output logic                done,
    output logic                err
);

    lsu_pkg::bus_req_t          bus_req;
    lsu_pkg::bus_rsp_t          bus_rsp;
    logic                       arvalid, awvalid, wvalid;
    logic                       arready, awready, wready;
    logic                       rvalid, bvalid;
    logic                       ar_fire, w_fire;
    logic [`LSU_NUM_BANKS-1:0]  sel_arvalid, sel_awvalid, sel_wvalid;
    logic [`LSU_NUM_BANKS-1:0]  bank_arready, bank_awready, bank_wready;
    logic [`LSU_NUM_BANKS-1:0]  bank_rvalid, bank_bvalid;
    lsu_pkg::bus_rsp_t          bank_rsp [`LSU_NUM_BANKS];
    logic [`LSU_BANK_IDX_W-1:0] tgt;
    logic                       unmapped;

    assign ar_fire = arvalid && arready;
    assign w_fire  = wvalid && wready;

    lsu u_lsu (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .wen     (wen),
        .ren     (ren),
        .sign    (sign),
        .size    (size),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .done    (done),
        .err     (err),
        .bus_req (bus_req),
        .arvalid (arvalid),
        .awvalid (awvalid),
        .wvalid  (wvalid),
        .rready  (),        // tied high inside lsu
        .bready  (),
        .arready (arready),
        .awready (awready),
        .wready  (wready),
        .rvalid  (rvalid),
        .bvalid  (bvalid),
        .bus_rsp (bus_rsp)
    );

    bus_decode u_decode (
        .addr         (bus_req.addr),
        .arvalid      (arvalid),
        .awvalid      (awvalid),
        .wvalid       (wvalid),
        .arready      (arready),
        .awready      (awready),
        .wready       (wready),
        .sel_arvalid  (sel_arvalid),
        .sel_awvalid  (sel_awvalid),
        .sel_wvalid   (sel_wvalid),
        .bank_arready (bank_arready),
        .bank_awready (bank_awready),
        .bank_wready  (bank_wready),
        .tgt          (tgt),
        .unmapped     (unmapped)
    );

    for (genvar i = 0; i < `LSU_NUM_BANKS; i++) begin : g_bank
        sram_bank u_bank (
            .clk     (clk),
            .reset   (reset),
            .req     (bus_req),
            .arvalid (sel_arvalid[i]),
            .awvalid (sel_awvalid[i]),
            .wvalid  (sel_wvalid[i]),
            .arready (bank_arready[i]),
            .awready (bank_awready[i]),
            .wready  (bank_wready[i]),
            .rsp     (bank_rsp[i]),
            .rvalid  (bank_rvalid[i]),
            .bvalid  (bank_bvalid[i])
        );
    end

    resp_select u_resp (
        .clk         (clk),
        .reset       (reset),
        .tgt         (tgt),
        .unmapped    (unmapped),
        .ar_fire     (ar_fire),
        .w_fire      (w_fire),
        .bank_rsp    (bank_rsp),
        .bank_rvalid (bank_rvalid),
        .bank_bvalid (bank_bvalid),
        .rsp         (bus_rsp),
        .rvalid      (rvalid),
        .bvalid      (bvalid)
    );

endmodule

// File: hdl/resp_select.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module resp_select (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`LSU_BANK_IDX_W-1:0]  tgt,
    input  logic                        unmapped,
    input  logic                        ar_fire,
    input  logic                        w_fire,
    input  lsu_pkg::bus_rsp_t           bank_rsp [`LSU_NUM_BANKS],
    input  logic [`LSU_NUM_BANKS-1:0]   bank_rvalid,
    input  logic [`LSU_NUM_BANKS-1:0]   bank_bvalid,
    output lsu_pkg::bus_rsp_t           rsp,
    output logic                        rvalid,
    output logic                        bvalid
);

    logic [`LSU_BANK_IDX_W-1:0] tgt_q;
    logic                       unmapped_q;
    logic                       dec_rvalid;
    logic                       dec_bvalid;

    always_ff @(posedge clk) begin
        if (reset) begin
            tgt_q      <= '0;
            unmapped_q <= 1'b0;
            dec_rvalid <= 1'b0;
            dec_bvalid <= 1'b0;
        end else begin
            if (ar_fire || w_fire) begin
                tgt_q      <= tgt;
                unmapped_q <= unmapped;
            end
            dec_rvalid <= ar_fire && unmapped; // local decode error
            dec_bvalid <= w_fire && unmapped;
        end
    end

    assign rvalid = unmapped_q ? dec_rvalid : bank_rvalid[tgt_q];
    assign bvalid = unmapped_q ? dec_bvalid : bank_bvalid[tgt_q];

    assign rsp.rdata = unmapped_q ? '0 : bank_rsp[tgt_q].rdata;
    assign rsp.resp  = unmapped_q ? lsu_pkg::RESP_DECERR : bank_rsp[tgt_q].resp;

endmodule

// File: hdl/sram_bank.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module sram_bank (
    input  logic                clk,
    input  logic                reset,
    input  lsu_pkg::bus_req_t   req,
    input  logic                arvalid,
    input  logic                awvalid,
    input  logic                wvalid,
    output logic                arready,
    output logic                awready,
    output logic                wready,
    output lsu_pkg::bus_rsp_t   rsp,
    output logic                rvalid,
    output logic                bvalid
);

    lsu_pkg::word_t mem [`LSU_BANK_WORDS];

    logic                       aw_pending;
    logic [`LSU_WORD_IDX_W-1:0] aw_idx;
    logic [`LSU_WORD_IDX_W-1:0] idx;
    lsu_pkg::word_t             rdata_q;
    logic                       busy;
    logic                       ar_fire;
    logic                       aw_fire;
    logic                       w_fire;

    assign idx  = req.addr[2 +: `LSU_WORD_IDX_W];
    assign busy = aw_pending || rvalid || bvalid;

    assign arready = !busy;
    assign awready = !busy;
    assign wready  = aw_pending; // data only after its address

    assign ar_fire = arvalid && arready;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_pending <= 1'b0;
            rvalid     <= 1'b0;
            bvalid     <= 1'b0;
        end else begin
            rvalid <= ar_fire;
            bvalid <= w_fire;
            if (aw_fire)
                aw_pending <= 1'b1;
            else if (w_fire)
                aw_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire)
            aw_idx <= idx;
        if (ar_fire)
            rdata_q <= mem[idx];
        if (w_fire) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b])
                    mem[aw_idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
            end
        end
    end

    assign rsp.rdata = rdata_q;
    assign rsp.resp  = lsu_pkg::RESP_OKAY;

endmodule

// File: include/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// address map
`define LSU_MEM_BASE 32'h8000_0000

// 256 bytes per bank
`define LSU_NUM_BANKS 4
`define LSU_BANK_WORDS 64

// index widths matching the counts above
`define LSU_BANK_IDX_W 2
`define LSU_WORD_IDX_W 6

`endif

// File: lsu_sys.f
+incdir+include
hdl/lsu_pkg.sv
hdl/lsu.sv
hdl/bus_decode.sv
hdl/sram_bank.sv
hdl/resp_select.sv
hdl/lsu_sys.sv
bench/lsu_checker.sv
bench/lsu_sys_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f lsu_sys.f \
    --top-module lsu_sys_tb \
    -Mdir obj_dir -o lsu_sys_sim

./obj_dir/lsu_sys_sim > sim.log 2>&1
cat sim.log

if grep -qx "TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
